// ==== verilog/clock_pkg.sv ====
`default_nettype none

package clock_pkg;

	// ----------------------------------------------------------------------
	// Value types
	// ----------------------------------------------------------------------
	typedef logic [5:0] field_t;		// Seconds or minutes, 0..59
	typedef logic [3:0] digit_t;		// One decimal digit
	typedef logic [6:0] seg_t;		// Segments a..g, a at MSB, active high
	typedef logic [3:0] digit_sel_t;	// Digit enables, active low

	typedef enum logic [1:0] {
		MODE_CLOCK = 2'b00,
		MODE_SETUP = 2'b01,
		MODE_ALARM = 2'b10
	} mode_t;

	// ----------------------------------------------------------------------
	// Limits and divider counts
	// ----------------------------------------------------------------------
	localparam field_t FIELD_MAX = 6'd59;

	// Small for simulation, raise for a board build
	localparam int CLK_PER_SEC = 200;
	localparam int CLK_PER_DIGIT = 4;	// Scan dwell per digit

	localparam int NUM_DIGITS = 4;

endpackage

`default_nettype wire

// ==== verilog/strobe_gen.sv ====
`default_nettype none

// One-cycle strobe every DIV clocks
module strobe_gen #(
	parameter int DIV = 4
) (
	input  wire  clk,
	input  wire  rst_n,
	output logic o_strobe
);

	localparam int CW = (DIV > 1) ? $clog2(DIV) : 1;

	logic [CW-1:0] cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (o_strobe) begin
			cnt <= '0;	// Wrap
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	assign o_strobe = (cnt == CW'(DIV - 1));

endmodule

`default_nettype wire

// ==== verilog/button_sync.sv ====
`default_nettype none

module button_sync (
	input  wire  clk,
	input  wire  rst_n,
	input  wire  i_btn_mode,
	input  wire  i_btn_pos,
	input  wire  i_btn_inc,
	input  wire  i_btn_alarm,
	output logic o_press_mode,
	output logic o_press_pos,
	output logic o_press_inc,
	output logic o_press_alarm
);

	logic [3:0] sync1;
	logic [3:0] sync2;
	logic [3:0] prev;	// Last synchronized level
	logic [3:0] press;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync1 <= '0;
			sync2 <= '0;
			prev  <= '0;
			press <= '0;
		end else begin
			sync1 <= {i_btn_alarm, i_btn_inc, i_btn_pos, i_btn_mode};
			sync2 <= sync1;
			prev  <= sync2;
			press <= sync2 & ~prev;	// Rising edge only
		end
	end

	assign o_press_mode  = press[0];
	assign o_press_pos   = press[1];
	assign o_press_inc   = press[2];
	assign o_press_alarm = press[3];

endmodule

`default_nettype wire

// ==== verilog/mode_ctrl.sv ====
`default_nettype none

module mode_ctrl import clock_pkg::*; (
	input  wire   clk,
	input  wire   rst_n,
	input  wire   i_press_mode,
	input  wire   i_press_pos,
	input  wire   i_press_inc,
	input  wire   i_press_alarm,
	input  wire   i_sec_tick,
	output mode_t o_mode,
	output logic  o_clk_tick,
	output logic  o_set_sec,
	output logic  o_set_min,
	output logic  o_alarm_set_sec,
	output logic  o_alarm_set_min,
	output logic  o_alarm_en
);

	logic pos_min;	// 0 = seconds, 1 = minutes

	// ----------------------------------------------------------------------
	// Mode FSM, position and alarm enable
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode     <= MODE_CLOCK;
			pos_min    <= 1'b0;
			o_alarm_en <= 1'b0;
		end else begin
			if (i_press_mode) begin
				case (o_mode)
					MODE_CLOCK: o_mode <= MODE_SETUP;
					MODE_SETUP: o_mode <= MODE_ALARM;
					default:    o_mode <= MODE_CLOCK;
				endcase
			end
			if (i_press_pos)
				pos_min <= ~pos_min;
			if (i_press_alarm)
				o_alarm_en <= ~o_alarm_en;
		end
	end

	// ----------------------------------------------------------------------
	// Strobe routing
	// ----------------------------------------------------------------------
	// Clock stops while being set
	assign o_clk_tick = i_sec_tick && (o_mode != MODE_SETUP);

	assign o_set_sec       = i_press_inc && (o_mode == MODE_SETUP) && !pos_min;
	assign o_set_min       = i_press_inc && (o_mode == MODE_SETUP) && pos_min;
	assign o_alarm_set_sec = i_press_inc && (o_mode == MODE_ALARM) && !pos_min;
	assign o_alarm_set_min = i_press_inc && (o_mode == MODE_ALARM) && pos_min;

endmodule

`default_nettype wire

// ==== verilog/time_counter.sv ====
`default_nettype none

module time_counter import clock_pkg::*; (
	input  wire    clk,
	input  wire    rst_n,
	input  wire    i_tick,
	input  wire    i_inc_sec,
	input  wire    i_inc_min,
	output field_t o_sec,
	output field_t o_min
);

	field_t sec_inc;
	field_t min_inc;
	logic   sec_wrap;

	// Next values, modulo 60
	assign sec_wrap = (o_sec >= FIELD_MAX);
	assign sec_inc  = sec_wrap ? '0 : o_sec + 1'b1;
	assign min_inc  = (o_min >= FIELD_MAX) ? '0 : o_min + 1'b1;

	// ----------------------------------------------------------------------
	// Tick carries into minutes, set increments do not
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_sec <= '0;
			o_min <= '0;
		end else begin
			if (i_tick || i_inc_sec)
				o_sec <= sec_inc;
			if ((i_tick && sec_wrap) || i_inc_min)
				o_min <= min_inc;	// Carry or manual set
		end
	end

endmodule

`default_nettype wire

// ==== verilog/alarm_unit.sv ====
`default_nettype none

module alarm_unit import clock_pkg::*; (
	input  wire    clk,
	input  wire    rst_n,
	input  wire    i_set_sec,
	input  wire    i_set_min,
	input  wire    i_alarm_en,
	input  field_t i_cur_sec,
	input  field_t i_cur_min,
	output field_t o_al_sec,
	output field_t o_al_min,
	output logic   o_alarm
);

	logic match;

	// Alarm time register, only moves on set strobes
	time_counter u_al_time (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_tick    (1'b0),
		.i_inc_sec (i_set_sec),
		.i_inc_min (i_set_min),
		.o_sec     (o_al_sec),
		.o_min     (o_al_min)
	);

	assign match = (i_cur_sec == o_al_sec) && (i_cur_min == o_al_min);

	// Latched flag, cleared only by disabling the alarm
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm <= 1'b0;
		end else if (!i_alarm_en) begin
			o_alarm <= 1'b0;
		end else if (match) begin
			o_alarm <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/seg_display.sv ====
`default_nettype none

module seg_display import clock_pkg::*; (
	input  wire        clk,
	input  wire        rst_n,
	input  mode_t      i_mode,
	input  field_t     i_cur_sec,
	input  field_t     i_cur_min,
	input  field_t     i_al_sec,
	input  field_t     i_al_min,
	output seg_t       o_seg,
	output digit_sel_t o_seg_enb
);

	logic       scan_tick;
	logic [1:0] scan;	// Active digit
	field_t     show_sec;
	field_t     show_min;
	digit_t     digit;

	function automatic seg_t seg_decode(input digit_t num);
		case (num)
			4'h0:    seg_decode = 7'b111_1110;
			4'h1:    seg_decode = 7'b011_0000;
			4'h2:    seg_decode = 7'b110_1101;
			4'h3:    seg_decode = 7'b111_1001;
			4'h4:    seg_decode = 7'b011_0011;
			4'h5:    seg_decode = 7'b101_1011;
			4'h6:    seg_decode = 7'b101_1111;
			4'h7:    seg_decode = 7'b111_0000;
			4'h8:    seg_decode = 7'b111_1111;
			4'h9:    seg_decode = 7'b111_0011;
			4'hA:    seg_decode = 7'b111_0111;
			4'hB:    seg_decode = 7'b001_1111;
			4'hC:    seg_decode = 7'b100_1110;
			4'hD:    seg_decode = 7'b011_1101;
			4'hE:    seg_decode = 7'b100_1111;
			default: seg_decode = 7'b100_0111;	// F
		endcase
	endfunction

	// ----------------------------------------------------------------------
	// Digit scan
	// ----------------------------------------------------------------------
	strobe_gen #(.DIV(CLK_PER_DIGIT)) u_scan_tick (
		.clk      (clk),
		.rst_n    (rst_n),
		.o_strobe (scan_tick)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan <= '0;
		end else if (scan_tick) begin
			scan <= (scan == 2'(NUM_DIGITS - 1)) ? '0 : scan + 1'b1;
		end
	end

	// Alarm time only in ALARM mode
	assign show_sec = (i_mode == MODE_ALARM) ? i_al_sec : i_cur_sec;
	assign show_min = (i_mode == MODE_ALARM) ? i_al_min : i_cur_min;

	always_comb begin
		case (scan)
			2'd0:    digit = digit_t'(show_sec % 6'd10);
			2'd1:    digit = digit_t'(show_sec / 6'd10);
			2'd2:    digit = digit_t'(show_min % 6'd10);
			default: digit = digit_t'(show_min / 6'd10);	// Minutes tens
		endcase
	end

	assign o_seg     = seg_decode(digit);
	assign o_seg_enb = ~(digit_sel_t'(1) << scan);

endmodule

`default_nettype wire

// ==== verilog/digital_clock_top.sv ====
`default_nettype none

module digital_clock_top import clock_pkg::*; (
	input  wire        clk,
	input  wire        rst_n,
	input  wire        i_btn_mode,
	input  wire        i_btn_pos,
	input  wire        i_btn_inc,
	input  wire        i_btn_alarm,
	output seg_t       o_seg,
	output digit_sel_t o_seg_enb,
	output logic       o_alarm
);

	logic   press_mode;
	logic   press_pos;
	logic   press_inc;
	logic   press_alarm;
	logic   sec_tick;
	logic   clk_tick;
	logic   set_sec;
	logic   set_min;
	logic   alarm_set_sec;
	logic   alarm_set_min;
	logic   alarm_en;
	mode_t  mode;
	field_t cur_sec;
	field_t cur_min;
	field_t al_sec;
	field_t al_min;

	// ----------------------------------------------------------------------
	// Inputs and control
	// ----------------------------------------------------------------------
	strobe_gen #(.DIV(CLK_PER_SEC)) u_sec_tick (
		.clk      (clk),
		.rst_n    (rst_n),
		.o_strobe (sec_tick)
	);

	button_sync u_btn (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_btn_mode    (i_btn_mode),
		.i_btn_pos     (i_btn_pos),
		.i_btn_inc     (i_btn_inc),
		.i_btn_alarm   (i_btn_alarm),
		.o_press_mode  (press_mode),
		.o_press_pos   (press_pos),
		.o_press_inc   (press_inc),
		.o_press_alarm (press_alarm)
	);

	mode_ctrl u_ctrl (
		.clk             (clk),
		.rst_n           (rst_n),
		.i_press_mode    (press_mode),
		.i_press_pos     (press_pos),
		.i_press_inc     (press_inc),
		.i_press_alarm   (press_alarm),
		.i_sec_tick      (sec_tick),
		.o_mode          (mode),
		.o_clk_tick      (clk_tick),
		.o_set_sec       (set_sec),
		.o_set_min       (set_min),
		.o_alarm_set_sec (alarm_set_sec),
		.o_alarm_set_min (alarm_set_min),
		.o_alarm_en      (alarm_en)
	);

	// ----------------------------------------------------------------------
	// Time, alarm and display
	// ----------------------------------------------------------------------
	time_counter u_time (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_tick    (clk_tick),
		.i_inc_sec (set_sec),
		.i_inc_min (set_min),
		.o_sec     (cur_sec),
		.o_min     (cur_min)
	);

	alarm_unit u_alarm (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_set_sec  (alarm_set_sec),
		.i_set_min  (alarm_set_min),
		.i_alarm_en (alarm_en),
		.i_cur_sec  (cur_sec),
		.i_cur_min  (cur_min),
		.o_al_sec   (al_sec),
		.o_al_min   (al_min),
		.o_alarm    (o_alarm)
	);

	seg_display u_disp (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_mode    (mode),
		.i_cur_sec (cur_sec),
		.i_cur_min (cur_min),
		.i_al_sec  (al_sec),
		.i_al_min  (al_min),
		.o_seg     (o_seg),
		.o_seg_enb (o_seg_enb)
	);

endmodule

`default_nettype wire

// ==== verif/tb_digital_clock.sv ====
`default_nettype none

module tb_digital_clock import clock_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// Button numbers and model modes
	localparam int B_MODE  = 0;
	localparam int B_POS   = 1;
	localparam int B_INC   = 2;
	localparam int B_ALARM = 3;

	localparam int M_CLOCK = 0;
	localparam int M_SETUP = 1;
	localparam int M_ALARM = 2;

	// Row actions
	localparam int A_FIXED = 0;	// Shown time and alarm output equal the model
	localparam int A_RUN   = 1;	// Next distinct reading is one second later
	localparam int A_SYNC  = 2;	// Frozen SETUP time taken into the model
	localparam int A_SET   = 3;	// Selected field stepped up to a target
	localparam int A_NEAR  = 4;	// Clock a few seconds past the model time
	localparam int A_PASS  = 5;	// Alarm time passes with the alarm off
	localparam int A_RING  = 6;	// Alarm output rises at the alarm time
	localparam int A_FLAG  = 7;	// Alarm output only

	typedef struct packed {
		int n_mode;
		int n_pos;
		int n_inc;
		int n_alarm;
		int wait_s;
		int act;
		int arg_min;
		int arg_sec;
	} step_t;

	logic       clk = 1'b0;
	logic       rst_n;
	logic       btn_mode;
	logic       btn_pos;
	logic       btn_inc;
	logic       btn_alarm;
	logic [6:0] seg;
	logic [3:0] seg_enb;
	logic       alarm_out;

	step_t steps[$];

	// Reference model state
	int m_mode;
	int m_pos;	// 0 = seconds, 1 = minutes
	int m_en;
	int m_flag;
	int m_min, m_sec;	// Clock time as last known
	int a_min, a_sec;	// Alarm time

	digital_clock_top dut0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_btn_mode  (btn_mode),
		.i_btn_pos   (btn_pos),
		.i_btn_inc   (btn_inc),
		.i_btn_alarm (btn_alarm),
		.o_seg       (seg),
		.o_seg_enb   (seg_enb),
		.o_alarm     (alarm_out)
	);

	always #5 clk = ~clk;

	// ----------------------------------------------------------------------
	// Failure reporting
	// ----------------------------------------------------------------------
	task automatic abort_run();
		$display("Something failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check(input int got, input int want, input string msg);
		if (got != want) begin
			$display("CHECK FAILED at %0t ns: %s (got %0d, expected %0d)",
				$time, msg, got, want);
			abort_run();
		end
	endtask

	task automatic give_up(input string what);
		$display("Timeout: %s", what);
		abort_run();
	endtask

	// ----------------------------------------------------------------------
	// Buttons and model
	// ----------------------------------------------------------------------
	task automatic drive_button(input int b, input logic level);
		case (b)
			B_MODE:  btn_mode = level;
			B_POS:   btn_pos = level;
			B_INC:   btn_inc = level;
			default: btn_alarm = level;
		endcase
	endtask

	task automatic model_press(input int b);
		case (b)
			B_MODE: m_mode = (m_mode + 1) % 3;
			B_POS:  m_pos = 1 - m_pos;
			B_INC: begin
				// Both set modes step one field with no carry
				if (m_mode == M_SETUP && m_pos == 0)
					m_sec = (m_sec + 1) % 60;
				else if (m_mode == M_SETUP)
					m_min = (m_min + 1) % 60;
				else if (m_mode == M_ALARM && m_pos == 0)
					a_sec = (a_sec + 1) % 60;
				else if (m_mode == M_ALARM)
					a_min = (a_min + 1) % 60;
			end
			default: begin
				m_en = 1 - m_en;
				if (m_en == 0)
					m_flag = 0;	// Disable clears the flag
			end
		endcase
	endtask

	task automatic press(input int b);
		@(negedge clk);
		drive_button(b, 1'b1);
		repeat (6) @(negedge clk);
		drive_button(b, 1'b0);
		repeat (6) @(negedge clk);
		model_press(b);
	endtask

	// ----------------------------------------------------------------------
	// Display reader
	// ----------------------------------------------------------------------
	function automatic int seg_to_digit(input logic [6:0] pattern);
		case (pattern)
			7'b111_1110: return 0;
			7'b011_0000: return 1;
			7'b110_1101: return 2;
			7'b111_1001: return 3;
			7'b011_0011: return 4;
			7'b101_1011: return 5;
			7'b101_1111: return 6;
			7'b111_0000: return 7;
			7'b111_1111: return 8;
			7'b111_0011: return 9;
			default:     return -1;
		endcase
	endfunction

	task automatic read_display(output int mm, output int ss);
		int         dig[$];
		int         tries;
		logic [3:0] want;
		for (int d = 0; d < NUM_DIGITS; d++) begin
			want = ~(4'b0001 << d);
			tries = 0;
			@(negedge clk);
			while (seg_enb !== want) begin
				tries++;
				if (tries > 8 * CLK_PER_DIGIT)
					give_up("digit enable never went low");
				@(negedge clk);
			end
			dig.push_back(seg_to_digit(seg));
			if (dig[d] < 0) begin
				$display("Unknown segment pattern %b on digit %0d", seg, d);
				abort_run();
			end
		end
		ss = dig[1] * 10 + dig[0];
		mm = dig[3] * 10 + dig[2];
	endtask

	// Two equal readings in a row mean no tick fell inside a scan
	task automatic read_stable(output int mm, output int ss);
		int pm, ps, tries;
		tries = 0;
		read_display(pm, ps);
		read_display(mm, ss);
		while (mm != pm || ss != ps) begin
			tries++;
			if (tries > 8)
				give_up("display never settled");
			pm = mm;
			ps = ss;
			read_display(mm, ss);
		end
	endtask

	// ----------------------------------------------------------------------
	// Row checks
	// ----------------------------------------------------------------------
	task automatic check_shown();
		int mm, ss;
		read_stable(mm, ss);
		if (m_mode == M_ALARM) begin
			check(mm, a_min, "alarm minutes shown");
			check(ss, a_sec, "alarm seconds shown");
		end else begin
			check(mm, m_min, "clock minutes shown");
			check(ss, m_sec, "clock seconds shown");
		end
		check(int'(alarm_out), m_flag, "alarm output");
	endtask

	task automatic check_run();
		int mm, ss, nm, ns, em, es, tries;
		tries = 0;
		read_stable(mm, ss);
		nm = mm;
		ns = ss;
		while (nm == mm && ns == ss) begin
			tries++;
			if (tries > 40)
				give_up("running time never advanced");
			read_stable(nm, ns);
		end
		es = ss + 1;
		em = mm;
		if (es == 60) begin
			es = 0;
			em = (mm + 1) % 60;	// Carry into minutes
		end
		check(nm, em, "minutes one second later");
		check(ns, es, "seconds one second later");
	endtask

	task automatic wait_for_time(input int want_min, input int want_sec);
		int mm, ss, tries;
		tries = 0;
		read_stable(mm, ss);
		while (mm != want_min || ss != want_sec) begin
			tries++;
			if (tries > 200)
				give_up("display never reached the alarm time");
			read_stable(mm, ss);
		end
	endtask

	task automatic add_step(input int n_mode, input int n_pos, input int n_inc,
			input int n_alarm, input int wait_s, input int act,
			input int arg_min, input int arg_sec);
		step_t s;
		s.n_mode  = n_mode;
		s.n_pos   = n_pos;
		s.n_inc   = n_inc;
		s.n_alarm = n_alarm;
		s.wait_s  = wait_s;
		s.act     = act;
		s.arg_min = arg_min;
		s.arg_sec = arg_sec;
		steps.push_back(s);
	endtask

	// ----------------------------------------------------------------------
	// Stimulus table and main loop
	// ----------------------------------------------------------------------
	initial begin
		int    mm, ss, diff, tries;
		step_t s;
		rst_n     = 1'b0;
		btn_mode  = 1'b0;
		btn_pos   = 1'b0;
		btn_inc   = 1'b0;
		btn_alarm = 1'b0;
		m_mode = M_CLOCK;
		m_pos  = 0;
		m_en   = 0;
		m_flag = 0;
		m_min  = 0;
		m_sec  = 0;
		a_min  = 0;
		a_sec  = 0;

		//       mode pos inc alarm wait action  min sec
		add_step(0, 0,  0, 0, 0, A_FIXED, 0,  0);	// Reset state
		add_step(0, 0,  0, 0, 0, A_RUN,   0,  0);
		add_step(0, 0,  0, 0, 0, A_RUN,   0,  0);
		add_step(1, 0,  0, 0, 0, A_SYNC,  0,  0);	// Into SETUP
		add_step(0, 0,  0, 0, 2, A_FIXED, 0,  0);	// Frozen
		add_step(0, 0, 60, 0, 0, A_FIXED, 0,  0);	// Seconds wrap past 59
		add_step(0, 0,  0, 0, 0, A_SET,   0, 57);
		add_step(0, 1,  2, 0, 0, A_FIXED, 0,  0);	// Minutes only
		add_step(0, 0,  0, 0, 0, A_SET,   1,  0);	// Clock 01:57
		add_step(1, 0,  2, 0, 0, A_FIXED, 0,  0);	// ALARM mode with alarm at 02:00
		add_step(0, 1,  3, 0, 0, A_FIXED, 0,  0);	// Alarm 02:03
		add_step(1, 0,  0, 0, 0, A_NEAR,  0,  0);	// Back to CLOCK
		add_step(0, 0,  0, 0, 0, A_RUN,   0,  0);
		add_step(0, 0,  0, 0, 0, A_RUN,   0,  0);
		add_step(0, 0,  0, 0, 0, A_RUN,   0,  0);
		add_step(0, 0,  0, 0, 0, A_PASS,  0,  0);	// Alarm still off
		add_step(1, 0,  0, 0, 0, A_SYNC,  0,  0);
		add_step(0, 0,  0, 0, 0, A_SET,   0,  0);
		add_step(0, 1,  0, 0, 0, A_SET,   2,  0);	// Clock 02:00
		add_step(2, 0,  0, 1, 0, A_FLAG,  0,  0);	// CLOCK mode with the alarm on
		add_step(0, 0,  0, 0, 0, A_RING,  0,  0);
		add_step(0, 0,  0, 0, 2, A_FLAG,  0,  0);	// Stays latched
		add_step(0, 0,  0, 1, 0, A_FLAG,  0,  0);	// Off clears it

		repeat (4) @(negedge clk);
		rst_n = 1'b1;

		for (int i = 0; i < steps.size(); i++) begin
			s = steps[i];
			repeat (s.n_mode) press(B_MODE);
			repeat (s.n_pos) press(B_POS);
			repeat (s.n_inc) press(B_INC);
			repeat (s.n_alarm) press(B_ALARM);
			repeat (s.wait_s * CLK_PER_SEC) @(negedge clk);
			case (s.act)
				A_FIXED: check_shown();
				A_RUN:   check_run();
				A_SYNC:  read_stable(m_min, m_sec);
				A_SET: begin
					while ((m_pos ? m_min : m_sec) != (m_pos ? s.arg_min : s.arg_sec))
						press(B_INC);
					check_shown();
				end
				A_NEAR: begin
					read_stable(mm, ss);
					diff = (mm * 60 + ss - (m_min * 60 + m_sec) + 3600) % 3600;
					check((diff <= 2) ? 1 : 0, 1,
						$sformatf("clock %0d s ahead of the set time", diff));
				end
				A_PASS: begin
					wait_for_time(a_min, a_sec);
					repeat (CLK_PER_SEC) @(negedge clk);
					check(int'(alarm_out), 0, "alarm output with alarm off");
				end
				A_RING: begin
					tries = 0;
					while (alarm_out !== 1'b1) begin
						@(negedge clk);
						tries++;
						if (tries > 10 * CLK_PER_SEC)
							give_up("alarm output never rose");
					end
					m_flag = 1;
					read_stable(mm, ss);
					check(mm, a_min, "minutes when the alarm rose");
					check(ss, a_sec, "seconds when the alarm rose");
				end
				A_FLAG:  check(int'(alarm_out), m_flag, "alarm output");
				default: give_up("unknown step action");
			endcase
		end

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
verilog/clock_pkg.sv
verilog/strobe_gen.sv
verilog/button_sync.sv
verilog/mode_ctrl.sv
verilog/time_counter.sv
verilog/alarm_unit.sv
verilog/seg_display.sv
verilog/digital_clock_top.sv
verif/tb_digital_clock.sv

// ==== Makefile ====
# Verilator simulation of the digital clock

TOP := tb_digital_clock

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --top-module $(TOP) -f sim.f
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir
